// ==== Bender.yml ====
package:
  name: memSubsystem

sources:
  - logic/memPkg.sv
  - logic/cp15Pkg.sv
  - logic/cp15Regs.sv
  - logic/instrCache.sv
  - logic/dataCache.sv
  - logic/busArbiter.sv
  - logic/busMemory.sv
  - logic/memSubsystem.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/memSubsystemTb.sv

// ==== logic/busArbiter.sv ====
`timescale 1ns/1ps

module busArbiter (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      iStrb,
  input  memPkg::memReqT            iReq,
  input  logic                      dStrb,
  input  memPkg::memReqT            dReq,
  output logic                      iReady,
  output logic                      dReady,
  output logic [memPkg::DataW-1:0]  rdDataOut,
  output logic                      memStrb,
  output memPkg::memReqT            memReq,
  input  logic                      memReady,
  input  logic [memPkg::DataW-1:0]  memRdData
);
  import memPkg::*;

  logic   busy;
  logic   ownerD;
  logic   iPendV;
  logic   dPendV;
  memReqT iPendReq;
  memReqT dPendReq;
  logic   iAvail;
  logic   dAvail;
  logic   issueI;
  logic   issueD;

  // A waiting slot or a fresh strobe
  assign iAvail = iPendV || iStrb;
  assign dAvail = dPendV || dStrb;

  // Bus frees up the cycle after ready, data wins
  assign issueD = !busy && dAvail;
  assign issueI = !busy && !dAvail && iAvail;

  assign memStrb = issueD || issueI;
  always_comb begin
    if (issueD) begin
      memReq = dPendV ? dPendReq : dReq;
    end else begin
      memReq = iPendV ? iPendReq : iReq;
    end
  end

  // Ready goes back to whoever owns the transfer
  assign iReady    = memReady && !ownerD;
  assign dReady    = memReady && ownerD;
  assign rdDataOut = memRdData;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy   <= 1'b0;
      ownerD <= 1'b0;
      iPendV <= 1'b0;
      dPendV <= 1'b0;
    end else begin
      if (memStrb) begin
        busy   <= 1'b1;
        ownerD <= issueD;
      end else if (memReady) begin
        busy <= 1'b0;
      end
      iPendV <= iAvail && !issueI;
      dPendV <= dAvail && !issueD;
    end
  end

  always_ff @(posedge clk) begin
    if (iStrb) begin
      iPendReq <= iReq;
    end
    if (dStrb) begin
      dPendReq <= dReq;
    end
  end

endmodule

// ==== logic/busMemory.sv ====
`timescale 1ns/1ps

module busMemory (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      reqStrb,
  input  memPkg::memReqT            req,
  output logic                      ready,
  output logic [memPkg::DataW-1:0]  rdData
);
  import memPkg::*;

  logic [DataW-1:0]   mem [MemWords];
  memReqT             reqQ;
  logic               busy;
  logic [WaitW-1:0]   waitCnt;
  logic               last;
  logic [MemIdxW-1:0] widx;

  // Ready is registered, so finish one count early
  assign last = busy && (waitCnt == WaitW'(MemWait - 1));
  assign widx = wordIdx(reqQ.addr);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy    <= 1'b0;
      ready   <= 1'b0;
      waitCnt <= '0;
    end else begin
      ready <= last;
      if (reqStrb) begin
        busy    <= 1'b1;
        waitCnt <= '0;
      end else if (last) begin
        busy <= 1'b0;
      end else if (busy) begin
        waitCnt <= waitCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqStrb) begin
      reqQ <= req;
    end
    if (last) begin
      if (reqQ.write) begin
        mem[widx] <= mergeBytes(mem[widx], reqQ.wrData, reqQ.byteMask);
      end
      // Read data on a write is don't care
      rdData <= mem[widx];
    end
  end

endmodule

// ==== logic/cp15Pkg.sv ====
package cp15Pkg;

  localparam int CtrlW      = 32;
  localparam int CtrlIEnBit = 12;
  localparam int CtrlDEnBit = 2;

  // Only the two cache enables are writable
  localparam logic [CtrlW-1:0] CtrlMask = (CtrlW'(1) << CtrlIEnBit) |
                                          (CtrlW'(1) << CtrlDEnBit);

  typedef enum logic [1:0] {
    CpWriteCtrl,
    CpInvICache,
    CpInvDCache,
    CpInvBoth
  } cpOpE;

  typedef struct packed {
    logic [31:13] rsvHi;
    logic         iEnable;
    logic [11:3]  rsvMid;
    logic         dEnable;
    logic [1:0]   rsvLo;
  } ctrlRegT;

endpackage

// ==== logic/cp15Regs.sv ====
`timescale 1ns/1ps

module cp15Regs (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        cpStrb,
  input  cp15Pkg::cpOpE               cpOp,
  input  logic [cp15Pkg::CtrlW-1:0]   cpWrData,
  output cp15Pkg::ctrlRegT            ctrl,
  output logic                        invI,
  output logic                        invD
);
  import cp15Pkg::*;

  logic nextInvI;
  logic nextInvD;

  // Decode maintenance operations
  always_comb begin
    nextInvI = 1'b0;
    nextInvD = 1'b0;
    if (cpStrb) begin
      case (cpOp)
        CpInvICache: begin
          nextInvI = 1'b1;
        end
        CpInvDCache: begin
          nextInvD = 1'b1;
        end
        CpInvBoth: begin
          nextInvI = 1'b1;
          nextInvD = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrl <= '0;
      invI <= 1'b0;
      invD <= 1'b0;
    end else begin
      // Strobes last exactly one cycle
      invI <= nextInvI;
      invD <= nextInvD;
      if (cpStrb && cpOp == CpWriteCtrl) begin
        // Reserved fields stay zero
        ctrl <= ctrlRegT'(cpWrData & CtrlMask);
      end
    end
  end

endmodule

// ==== logic/dataCache.sv ====
`timescale 1ns/1ps

module dataCache (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      enable,
  input  logic                      invalidate,
  input  logic                      reqStrb,
  input  memPkg::memReqT            req,
  output logic                      rspStrb,
  output logic [memPkg::DataW-1:0]  rdData,
  output logic                      busStrb,
  output memPkg::memReqT            busReq,
  input  logic                      busReady,
  input  logic [memPkg::DataW-1:0]  busRdData
);
  import memPkg::*;

  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Miss
  } stateE;

  stateE            state;
  stateE            stateNext;
  memReqT           reqQ;
  logic [CacheLines-1:0] valid;
  logic [TagW-1:0]  tagArr [CacheLines];
  logic [DataW-1:0] dataArr [CacheLines];
  logic [IdxW-1:0]  idx;
  logic             hit;
  logic             loadHit;
  logic             done;
  logic             fill;
  logic             storeMerge;

  assign idx     = lineIdx(reqQ.addr);
  assign hit     = enable && valid[idx] && (tagArr[idx] == lineTag(reqQ.addr));
  // Stores always go out on the bus
  assign loadHit = hit && !reqQ.write;
  assign done    = (state == Miss) && busReady;

  // Write-through, no allocate on a store miss
  assign fill       = done && enable && !reqQ.write;
  assign storeMerge = done && reqQ.write && hit;

  always_comb begin
    stateNext = state;
    case (state)
      Idle:    if (reqStrb) stateNext = Lookup;
      Lookup:  stateNext = loadHit ? Idle : Miss;
      Miss:    if (busReady) stateNext = Idle;
      default: stateNext = Idle;
    endcase
  end

  assign rspStrb = ((state == Lookup) && loadHit) || done;
  assign rdData  = (state == Lookup) ? dataArr[idx] : busRdData;

  assign busStrb = (state == Lookup) && !loadHit;
  assign busReq  = reqQ;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= Idle;
      valid <= '0;
    end else begin
      state <= stateNext;
      if (invalidate) begin
        valid <= '0;
      end else if (fill) begin
        valid[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && reqStrb) begin
      reqQ <= req;
    end
    if (fill) begin
      tagArr[idx]  <= lineTag(reqQ.addr);
      dataArr[idx] <= busRdData;
    end else if (storeMerge) begin
      // Keep the cached copy in step with memory
      dataArr[idx] <= mergeBytes(dataArr[idx], reqQ.wrData, reqQ.byteMask);
    end
  end

endmodule

// ==== logic/instrCache.sv ====
`timescale 1ns/1ps

module instrCache (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      enable,
  input  logic                      invalidate,
  input  logic                      reqStrb,
  input  memPkg::fetchReqT          req,
  output logic                      rspStrb,
  output logic [memPkg::DataW-1:0]  rdData,
  output logic                      busStrb,
  output memPkg::memReqT            busReq,
  input  logic                      busReady,
  input  logic [memPkg::DataW-1:0]  busRdData
);
  import memPkg::*;

  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Miss
  } stateE;

  stateE            state;
  stateE            stateNext;
  fetchReqT         reqQ;
  logic [CacheLines-1:0] valid;
  logic [TagW-1:0]  tagArr [CacheLines];
  logic [DataW-1:0] dataArr [CacheLines];
  logic [IdxW-1:0]  idx;
  logic             hit;
  logic             fill;

  assign idx  = lineIdx(reqQ.addr);
  // A disabled cache never hits
  assign hit  = enable && valid[idx] && (tagArr[idx] == lineTag(reqQ.addr));
  assign fill = (state == Miss) && busReady && enable;

  always_comb begin
    stateNext = state;
    case (state)
      Idle:    if (reqStrb) stateNext = Lookup;
      Lookup:  stateNext = hit ? Idle : Miss;
      Miss:    if (busReady) stateNext = Idle;
      default: stateNext = Idle;
    endcase
  end

  assign rspStrb = ((state == Lookup) && hit) || ((state == Miss) && busReady);
  assign rdData  = (state == Lookup) ? dataArr[idx] : busRdData;

  // Read only port, full word
  assign busStrb         = (state == Lookup) && !hit;
  assign busReq.addr     = reqQ.addr;
  assign busReq.write    = 1'b0;
  assign busReq.wrData   = '0;
  assign busReq.byteMask = '1;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= Idle;
      valid <= '0;
    end else begin
      state <= stateNext;
      if (invalidate) begin
        valid <= '0;
      end else if (fill) begin
        valid[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && reqStrb) begin
      reqQ <= req;
    end
    if (fill) begin
      tagArr[idx]  <= lineTag(reqQ.addr);
      dataArr[idx] <= busRdData;
    end
  end

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

  localparam int AddrW      = 32;
  localparam int DataW      = 32;
  localparam int MaskW      = DataW / 8;
  localparam int OffW       = 2;

  // Backing memory, word addressed by byte address bits 11:2
  localparam int MemWords   = 1024;
  localparam int MemIdxW    = $clog2(MemWords);
  localparam int MemWait    = 2;
  localparam int WaitW      = $clog2(MemWait + 1);

  // Direct mapped caches with one-word lines
  localparam int CacheLines = 16;
  localparam int IdxW       = $clog2(CacheLines);
  localparam int TagW       = AddrW - IdxW - OffW;

  typedef struct packed {
    logic [AddrW-1:0] addr;
    logic             write;
    logic [DataW-1:0] wrData;
    logic [MaskW-1:0] byteMask;
  } memReqT;

  typedef struct packed {
    logic [AddrW-1:0] addr;
  } fetchReqT;

  function automatic logic [IdxW-1:0] lineIdx(logic [AddrW-1:0] addr);
    return addr[OffW +: IdxW];
  endfunction

  function automatic logic [TagW-1:0] lineTag(logic [AddrW-1:0] addr);
    return addr[AddrW-1 -: TagW];
  endfunction

  function automatic logic [MemIdxW-1:0] wordIdx(logic [AddrW-1:0] addr);
    return addr[OffW +: MemIdxW];
  endfunction

  // Replace only the bytes selected by the mask
  function automatic logic [DataW-1:0] mergeBytes(logic [DataW-1:0] oldWord,
                                                  logic [DataW-1:0] newWord,
                                                  logic [MaskW-1:0] mask);
    logic [DataW-1:0] res;
    res = oldWord;
    for (int b = 0; b < MaskW; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        fetchStrb,
  input  memPkg::fetchReqT            fetchReq,
  output logic                        fetchRspStrb,
  output logic [memPkg::DataW-1:0]    fetchData,
  input  logic                        dataStrb,
  input  memPkg::memReqT              dataReq,
  output logic                        dataRspStrb,
  output logic [memPkg::DataW-1:0]    dataRdData,
  input  logic                        cpStrb,
  input  cp15Pkg::cpOpE               cpOp,
  input  logic [cp15Pkg::CtrlW-1:0]   cpWrData,
  output cp15Pkg::ctrlRegT            cpCtrl
);
  import memPkg::*;

  logic             iEnable;
  logic             dEnable;
  logic             invI;
  logic             invD;
  logic             iBusStrb;
  logic             dBusStrb;
  logic             iBusReady;
  logic             dBusReady;
  logic             memStrb;
  logic             memReady;
  memReqT           iBusReq;
  memReqT           dBusReq;
  memReqT           memReq;
  logic [DataW-1:0] busRdData;
  logic [DataW-1:0] memRdData;

  // Cache enables straight from the control register
  assign iEnable = cpCtrl.iEnable;
  assign dEnable = cpCtrl.dEnable;

  cp15Regs cp15 (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .cpStrb  (cpStrb  ),
    .cpOp    (cpOp    ),
    .cpWrData(cpWrData),
    .ctrl    (cpCtrl  ),
    .invI    (invI    ),
    .invD    (invD    )
  );

  instrCache iCache (
    .clk       (clk         ),
    .rstN      (rstN        ),
    .enable    (iEnable     ),
    .invalidate(invI        ),
    .reqStrb   (fetchStrb   ),
    .req       (fetchReq    ),
    .rspStrb   (fetchRspStrb),
    .rdData    (fetchData   ),
    .busStrb   (iBusStrb    ),
    .busReq    (iBusReq     ),
    .busReady  (iBusReady   ),
    .busRdData (busRdData   )
  );

  dataCache dCache (
    .clk       (clk        ),
    .rstN      (rstN       ),
    .enable    (dEnable    ),
    .invalidate(invD       ),
    .reqStrb   (dataStrb   ),
    .req       (dataReq    ),
    .rspStrb   (dataRspStrb),
    .rdData    (dataRdData ),
    .busStrb   (dBusStrb   ),
    .busReq    (dBusReq    ),
    .busReady  (dBusReady  ),
    .busRdData (busRdData  )
  );

  busArbiter arb (
    .clk      (clk      ),
    .rstN     (rstN     ),
    .iStrb    (iBusStrb ),
    .iReq     (iBusReq  ),
    .dStrb    (dBusStrb ),
    .dReq     (dBusReq  ),
    .iReady   (iBusReady),
    .dReady   (dBusReady),
    .rdDataOut(busRdData),
    .memStrb  (memStrb  ),
    .memReq   (memReq   ),
    .memReady (memReady ),
    .memRdData(memRdData)
  );

  busMemory mem (
    .clk    (clk      ),
    .rstN   (rstN     ),
    .reqStrb(memStrb  ),
    .req    (memReq   ),
    .ready  (memReady ),
    .rdData (memRdData)
  );

endmodule

// ==== tb.f ====
+incdir+verification
logic/memPkg.sv
logic/cp15Pkg.sv
logic/cp15Regs.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/busMemory.sv
logic/memSubsystem.sv
verification/memSubsystemTb.sv

// ==== verification/memSubsystemTests.svh ====
`ifndef MEM_SUBSYSTEM_TESTS_SVH
`define MEM_SUBSYSTEM_TESTS_SVH

// Both caches off so every access goes to memory
task automatic uncachedRoundTrip();
  int lat;
  cpAccess(CpWriteCtrl, '0);
  for (int i = 0; i < 8; i++) begin
    storeWord(32'h100 + i * 32'h44, randBits(32), 4'hf);
  end
  for (int i = 0; i < 8; i++) begin
    loadAndCheck(32'h100 + i * 32'h44, lat);
    fetchAndCheck(32'h100 + i * 32'h44, lat);
  end
endtask

task automatic ctrlRegisterMask();
  @(negedge clk);
  checkWord("Control register after reset", cpCtrl, '0);
  cpAccess(CpWriteCtrl, '1);
  @(negedge clk);
  // Only the two enables survive
  checkWord("Control register after all ones", cpCtrl, (32'd1 << 12) | (32'd1 << 2));
  cpAccess(CpWriteCtrl, '0);
  @(negedge clk);
  checkWord("Control register after clear", cpCtrl, '0);
endtask

task automatic dataHitLatency();
  int lat;
  storeWord(32'h300, randBits(32), 4'hf);
  cpAccess(CpWriteCtrl, 32'd1 << 2);
  loadAndCheck(32'h300, lat);
  assert (lat > 1) else begin
    $display("ERR %0t ns: load miss answered after %0d cycle", $time, lat);
    stopOnFailure();
  end
  loadAndCheck(32'h300, lat);
  checkWord("Load hit latency", lat, 1);
endtask

task automatic staleFetchAfterStore();
  logic [DataW-1:0] oldWord;
  logic [DataW-1:0] rd;
  int               lat;
  storeWord(32'h344, randBits(32), 4'hf);
  cpAccess(CpWriteCtrl, '1);
  fetchAndCheck(32'h344, lat);
  oldWord = shadow[MemIdxW'(32'h344 >> 2)];
  storeWord(32'h344, randBits(32), 4'hf);
  // Instruction cache does not snoop data stores
  fetchAccess(32'h344, rd, lat);
  checkWord("Stale fetch hit", rd, oldWord);
  cpAccess(CpInvICache, '0);
  fetchAndCheck(32'h344, lat);
endtask

task automatic byteMaskStores();
  logic [3:0] mask;
  int         lat;
  cpAccess(CpWriteCtrl, 32'd1 << 2);
  storeWord(32'h388, randBits(32), 4'hf);
  storeWord(32'h3cc, randBits(32), 4'hf);
  loadAndCheck(32'h388, lat);
  for (int k = 0; k < 4; k++) begin
    mask = 4'(randBits(4));
    if (mask == 4'h0) begin
      mask = 4'h8;
    end
    storeWord(32'h388, randBits(32), mask);
    storeWord(32'h3cc, randBits(32), mask);
    loadAndCheck(32'h388, lat);
  end
  loadAndCheck(32'h3cc, lat);
  fetchAndCheck(32'h388, lat);
  fetchAndCheck(32'h3cc, lat);
endtask

// Fetch and load strobed in the same cycle and both missing
task automatic missPair(input logic [AddrW-1:0] fAddr, input logic [AddrW-1:0] dAddr);
  memReqT           dReq;
  fetchReqT         fReq;
  logic             fSeen;
  logic             dSeen;
  logic [DataW-1:0] fRd;
  logic [DataW-1:0] dRd;
  int               cycles;
  fReq.addr     = fAddr;
  dReq.addr     = dAddr;
  dReq.write    = 1'b0;
  dReq.wrData   = '0;
  dReq.byteMask = 4'hf;
  @(posedge clk);
  fetchStrb <= 1'b1;
  fetchReq  <= fReq;
  dataStrb  <= 1'b1;
  dataReq   <= dReq;
  @(posedge clk);
  fetchStrb <= 1'b0;
  dataStrb  <= 1'b0;
  fSeen  = 1'b0;
  dSeen  = 1'b0;
  cycles = 0;
  while (!(fSeen && dSeen) && cycles < RspLimit) begin
    @(negedge clk);
    cycles++;
    if (fetchRspStrb) begin
      fSeen = 1'b1;
      fRd   = fetchData;
    end
    if (dataRspStrb) begin
      dSeen = 1'b1;
      dRd   = dataRdData;
    end
  end
  assert (fSeen && dSeen) else begin
    $display("Simultaneous fetch and load did not both finish within %0d cycles", RspLimit);
    stopOnFailure();
  end
  checkWord($sformatf("Paired fetch from %08h", fAddr), fRd, shadow[fAddr[11:2]]);
  checkWord($sformatf("Paired load from %08h", dAddr), dRd, shadow[dAddr[11:2]]);
endtask

task automatic simultaneousMisses();
  cpAccess(CpWriteCtrl, '1);
  cpAccess(CpInvBoth, '0);
  storeWord(32'h400, randBits(32), 4'hf);
  storeWord(32'h444, randBits(32), 4'hf);
  missPair(32'h400, 32'h444);
  // Swapped so each cache misses again
  missPair(32'h444, 32'h400);
endtask

`endif

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;
  import memPkg::*;
  import cp15Pkg::*;

  localparam int ClkPeriod     = 4;
  localparam int ResetCycles   = 8;
  localparam int TestCount     = 6;
  localparam int CyclesPerTest = 400;
  localparam int RspLimit      = 50;
  localparam logic [31:0] LfsrSeed = 32'hacc7_7f1b;

  logic             clk;
  logic             rstN;
  logic             fetchStrb;
  fetchReqT         fetchReq;
  logic             fetchRspStrb;
  logic [DataW-1:0] fetchData;
  logic             dataStrb;
  memReqT           dataReq;
  logic             dataRspStrb;
  logic [DataW-1:0] dataRdData;
  logic             cpStrb;
  cpOpE             cpOp;
  logic [CtrlW-1:0] cpWrData;
  ctrlRegT          cpCtrl;

  logic [31:0]      lfsr;
  // Expected memory contents, one entry per word
  logic [DataW-1:0] shadow [MemWords];

  memSubsystem dut0 (
    .clk         (clk         ),
    .rstN        (rstN        ),
    .fetchStrb   (fetchStrb   ),
    .fetchReq    (fetchReq    ),
    .fetchRspStrb(fetchRspStrb),
    .fetchData   (fetchData   ),
    .dataStrb    (dataStrb    ),
    .dataReq     (dataReq     ),
    .dataRspStrb (dataRspStrb ),
    .dataRdData  (dataRdData  ),
    .cpStrb      (cpStrb      ),
    .cpOp        (cpOp        ),
    .cpWrData    (cpWrData    ),
    .cpCtrl      (cpCtrl      )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Budget covers reset plus every test
  initial begin
    #((ResetCycles + TestCount * CyclesPerTest) * ClkPeriod);
    $display("Watchdog expired before the test sequence finished");
    stopOnFailure();
  end

  task automatic stopOnFailure();
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic checkWord(input string what, input logic [DataW-1:0] got,
                           input logic [DataW-1:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t ns: %s gave %08h, expected %08h", $time, what, got, exp);
      stopOnFailure();
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [DataW-1:0] maskedWord(input logic [DataW-1:0] prev,
                                                  input logic [DataW-1:0] wr,
                                                  input logic [3:0] mask);
    logic [DataW-1:0] bits;
    bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (prev & ~bits) | (wr & bits);
  endfunction

  // Cycles count from the edge where the DUT takes the strobe
  task automatic dataAccess(input memReqT req, output logic [DataW-1:0] rd,
                            output int cycles);
    @(posedge clk);
    dataStrb <= 1'b1;
    dataReq  <= req;
    @(posedge clk);
    dataStrb <= 1'b0;
    @(negedge clk);
    cycles = 1;
    while (!dataRspStrb && cycles < RspLimit) begin
      @(negedge clk);
      cycles++;
    end
    assert (dataRspStrb) else begin
      $display("No response on the data port within %0d cycles", RspLimit);
      stopOnFailure();
    end
    rd = dataRdData;
  endtask

  task automatic fetchAccess(input logic [AddrW-1:0] addr, output logic [DataW-1:0] rd,
                             output int cycles);
    fetchReqT req;
    req.addr = addr;
    @(posedge clk);
    fetchStrb <= 1'b1;
    fetchReq  <= req;
    @(posedge clk);
    fetchStrb <= 1'b0;
    @(negedge clk);
    cycles = 1;
    while (!fetchRspStrb && cycles < RspLimit) begin
      @(negedge clk);
      cycles++;
    end
    assert (fetchRspStrb) else begin
      $display("No response on the fetch port within %0d cycles", RspLimit);
      stopOnFailure();
    end
    rd = fetchData;
  endtask

  task automatic storeWord(input logic [AddrW-1:0] addr, input logic [DataW-1:0] wr,
                           input logic [3:0] mask);
    memReqT           req;
    logic [DataW-1:0] rd;
    int               cycles;
    req.addr     = addr;
    req.write    = 1'b1;
    req.wrData   = wr;
    req.byteMask = mask;
    dataAccess(req, rd, cycles);
    shadow[addr[11:2]] = maskedWord(shadow[addr[11:2]], wr, mask);
  endtask

  task automatic loadAndCheck(input logic [AddrW-1:0] addr, output int cycles);
    memReqT           req;
    logic [DataW-1:0] rd;
    req.addr     = addr;
    req.write    = 1'b0;
    req.wrData   = '0;
    req.byteMask = 4'hf;
    dataAccess(req, rd, cycles);
    checkWord($sformatf("Load from %08h", addr), rd, shadow[addr[11:2]]);
  endtask

  task automatic fetchAndCheck(input logic [AddrW-1:0] addr, output int cycles);
    logic [DataW-1:0] rd;
    fetchAccess(addr, rd, cycles);
    checkWord($sformatf("Fetch from %08h", addr), rd, shadow[addr[11:2]]);
  endtask

  // No response strobe; the extra cycles let an invalidate finish
  task automatic cpAccess(input cpOpE op, input logic [CtrlW-1:0] wr);
    @(posedge clk);
    cpStrb   <= 1'b1;
    cpOp     <= op;
    cpWrData <= wr;
    @(posedge clk);
    cpStrb <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  `include "memSubsystemTests.svh"

  initial begin
    lfsr      = LfsrSeed;
    rstN      = 1'b0;
    fetchStrb = 1'b0;
    fetchReq  = '0;
    dataStrb  = 1'b0;
    dataReq   = '0;
    cpStrb    = 1'b0;
    cpOp      = CpWriteCtrl;
    cpWrData  = '0;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    uncachedRoundTrip();
    ctrlRegisterMask();
    dataHitLatency();
    staleFetchAfterStore();
    byteMaskStores();
    simultaneousMisses();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
